/* hw/sram_map_pkg.sv */
package sram_map_pkg;

  // ------------------------------------------------------------
  // Widths seen at the port
  // ------------------------------------------------------------

  // Byte address as presented by the requester
  typedef logic [15:0] byte_addr_t;

  // One data word, also used for the macro bit mask
  typedef logic [31:0] word_t;

  // Byte write strobes, all zero is a read
  typedef logic [3:0] strobe_t;

  // Outcome of the address decode
  typedef enum logic [1:0] {
    bank_0,
    bank_1,
    bank_none
  } bank_t;

  // ------------------------------------------------------------
  // Address map
  // ------------------------------------------------------------

  // Bank 0, 16 KB at the bottom
  localparam byte_addr_t bank0_base  = 16'h0000;
  localparam byte_addr_t bank0_limit = 16'h3fff;

  // Bank 1, 32 KB in the upper half
  localparam byte_addr_t bank1_base  = 16'h8000;
  localparam byte_addr_t bank1_limit = 16'hffff;

  // Byte address widths handed to the wrappers
  localparam int bank0_addr_width = 14;
  localparam int bank1_addr_width = 15;

endpackage

/* hw/sram_bus_pkg.sv */
package sram_bus_pkg;

  // Field types come from the address map
  import sram_map_pkg::*;

  // ------------------------------------------------------------
  // Request channel payload
  // ------------------------------------------------------------

  // One word access
  // Strobes select written bytes, none set means read
  typedef struct packed {
    byte_addr_t addr;
    word_t      wdata;
    strobe_t    wstrb;
  } sram_req_t;

  // ------------------------------------------------------------
  // Response channel payload
  // ------------------------------------------------------------

  // Read data is zero for writes and for unmapped accesses
  // Error only for the hole between the banks
  typedef struct packed {
    word_t rdata;
    logic  error;
  } sram_rsp_t;

  // Packed widths, 52 and 33 bits
  // Handy for waveform grouping
  // and for sizing bus pipelines
  // outside this block
  //
  // addr  [51:36]
  // wdata [35:4]
  // wstrb [3:0]
  //
  // rdata [32:1]
  // error [0]

endpackage

/* hw/sram_macro.sv */
`timescale 1ns/10ps

module sram_macro #(
  parameter int words = 4096
) (
  input  logic                       clk,
  input  logic                       cen,
  input  logic                       gwen,
  input  sram_map_pkg::word_t        wen,
  input  logic [$clog2(words)-1:0]   a,
  input  sram_map_pkg::word_t        d,
  output sram_map_pkg::word_t        q
);

  import sram_map_pkg::*;

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------

  // Contents start unknown, as on silicon
  word_t mem [words];

  // Current contents of the addressed word
  word_t cur_word;

  assign cur_word = mem[a];

  // ------------------------------------------------------------
  // Single port access
  // ------------------------------------------------------------

  // Active low enables throughout
  always_ff @(posedge clk) begin
    if (!cen) begin
      if (!gwen) begin
        // Bits with wen low take new data
        mem[a] <= (d & ~wen) | (cur_word & wen);
      end else begin
        // Read, data appears after this edge
        q <= cur_word;
      end
    end
    // Deselected or writing, q keeps its value
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  // Selected access must stay inside the array
  a_addr_in_range: assert property (
    @(posedge clk) !cen |-> (32'(a) < words)
  ) else $error("sram_macro: address %0h beyond %0d words", a, words);

endmodule

/* hw/sl_sram.sv */
`timescale 1ns/10ps

module sl_sram #(
  parameter int addr_width = 14
) (
  input  logic                    clk,
  input  logic [addr_width-1:2]   addr,
  input  sram_map_pkg::word_t     wdata,
  input  sram_map_pkg::strobe_t   wren,
  input  logic                    cs,
  output sram_map_pkg::word_t     rdata
);

  import sram_map_pkg::*;

  // ------------------------------------------------------------
  // Active low pin mapping
  // ------------------------------------------------------------

  logic  macro_cen;
  logic  macro_gwen;
  word_t macro_wen;
  word_t macro_q;

  // Chip enable
  assign macro_cen = ~cs;

  // Global write enable, high when no byte is written
  assign macro_gwen = ~(|wren);

  // Per byte strobe stretched to eight mask bits
  assign macro_wen = {
    {8{~wren[3]}},
    {8{~wren[2]}},
    {8{~wren[1]}},
    {8{~wren[0]}}
  };

  assign rdata = macro_q;

  // ------------------------------------------------------------
  // Macro selection by address width
  // ------------------------------------------------------------

  generate
    if (addr_width == bank0_addr_width) begin : g_16k
      // 16 KB, 4096 words
      sram_macro #(
        .words (2 ** (bank0_addr_width - 2))
      ) u_sram (
        .clk  (clk),
        .cen  (macro_cen),
        .gwen (macro_gwen),
        .wen  (macro_wen),
        .a    (addr),
        .d    (wdata),
        .q    (macro_q)
      );
    end else if (addr_width == bank1_addr_width) begin : g_32k
      // 32 KB, 8192 words
      sram_macro #(
        .words (2 ** (bank1_addr_width - 2))
      ) u_sram (
        .clk  (clk),
        .cen  (macro_cen),
        .gwen (macro_gwen),
        .wen  (macro_wen),
        .a    (addr),
        .d    (wdata),
        .q    (macro_q)
      );
    end else begin : g_bad_width
      // Only the two compiled sizes exist
      $error("sl_sram: no macro for addr_width %0d", addr_width);
    end
  endgenerate

endmodule

/* hw/sram_port.sv */
`timescale 1ns/10ps

module sram_port (
  input  logic                                        clk,
  input  logic                                        reset,

  // Request channel
  input  sram_bus_pkg::sram_req_t                     req,
  input  logic                                        req_valid,
  output logic                                        req_ready,

  // Response channel
  output sram_bus_pkg::sram_rsp_t                     rsp,
  output logic                                        rsp_valid,
  input  logic                                        rsp_ready,

  // Bank 0 wrapper
  output logic                                        bank0_cs,
  output logic [sram_map_pkg::bank0_addr_width-1:2]   bank0_addr,
  output sram_map_pkg::word_t                         bank0_wdata,
  output sram_map_pkg::strobe_t                       bank0_wren,
  input  sram_map_pkg::word_t                         bank0_rdata,

  // Bank 1 wrapper
  output logic                                        bank1_cs,
  output logic [sram_map_pkg::bank1_addr_width-1:2]   bank1_addr,
  output sram_map_pkg::word_t                         bank1_wdata,
  output sram_map_pkg::strobe_t                       bank1_wren,
  input  sram_map_pkg::word_t                         bank1_rdata
);

  import sram_map_pkg::*;

  // Record of the access whose response is pending
  typedef struct packed {
    bank_t bank;
    logic  write;
  } pend_t;

  // ------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------

  // Offset compare works for any base, including zero
  function automatic bank_t decode(input byte_addr_t addr);
    bank_t res;
    res = bank_none;
    if (byte_addr_t'(addr - bank0_base) <= byte_addr_t'(bank0_limit - bank0_base)) begin
      res = bank_0;
    end else if (byte_addr_t'(addr - bank1_base) <=
                 byte_addr_t'(bank1_limit - bank1_base)) begin
      res = bank_1;
    end
    return res;
  endfunction

  bank_t req_bank;
  logic  req_fire;
  pend_t pend;

  assign req_bank = decode(req.addr);

  // Free slot, or the pending response leaves this cycle
  assign req_ready = ~rsp_valid | rsp_ready;
  assign req_fire  = req_valid & req_ready;

  // ------------------------------------------------------------
  // Bank drive
  // ------------------------------------------------------------

  // Select only in the accepting cycle
  assign bank0_cs = req_fire & (req_bank == bank_0);
  assign bank1_cs = req_fire & (req_bank == bank_1);

  // Word address, trimmed to each bank
  assign bank0_addr = req.addr[bank0_addr_width-1:2];
  assign bank1_addr = req.addr[bank1_addr_width-1:2];

  assign bank0_wdata = req.wdata;
  assign bank1_wdata = req.wdata;

  assign bank0_wren = req.wstrb;
  assign bank1_wren = req.wstrb;

  // ------------------------------------------------------------
  // Response register
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_valid  <= 1'b0;
      pend.bank  <= bank_none;
      pend.write <= 1'b0;
    end else if (req_fire) begin
      // New access, response next cycle
      rsp_valid  <= 1'b1;
      pend.bank  <= req_bank;
      pend.write <= |req.wstrb;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  // Payload from the record and the bank output
  // Bank rdata holds until that bank is selected again
  always_comb begin
    rsp.error = (pend.bank == bank_none);
    rsp.rdata = '0;
    if (!pend.write) begin
      case (pend.bank)
        bank_0:  rsp.rdata = bank0_rdata;
        bank_1:  rsp.rdata = bank1_rdata;
        default: rsp.rdata = '0;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  // Stalled response keeps valid and payload
  a_rsp_stable: assert property (
    @(posedge clk) disable iff (reset)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp)
  ) else $error("sram_port: response changed under back-pressure");

  // One bank per access
  a_one_bank: assert property (
    @(posedge clk) disable iff (reset)
    !(bank0_cs && bank1_cs)
  ) else $error("sram_port: both banks selected");

endmodule

/* hw/sram_subsystem.sv */
`timescale 1ns/10ps

module sram_subsystem (
  input  logic                      clk,
  input  logic                      reset,

  // Request channel
  input  sram_bus_pkg::sram_req_t   req,
  input  logic                      req_valid,
  output logic                      req_ready,

  // Response channel
  output sram_bus_pkg::sram_rsp_t   rsp,
  output logic                      rsp_valid,
  input  logic                      rsp_ready
);

  import sram_map_pkg::*;

  // ------------------------------------------------------------
  // Bank wiring
  // ------------------------------------------------------------

  logic                          bank0_cs;
  logic [bank0_addr_width-1:2]   bank0_addr;
  word_t                         bank0_wdata;
  strobe_t                       bank0_wren;
  word_t                         bank0_rdata;

  logic                          bank1_cs;
  logic [bank1_addr_width-1:2]   bank1_addr;
  word_t                         bank1_wdata;
  strobe_t                       bank1_wren;
  word_t                         bank1_rdata;

  // Handshakes, decode and response
  sram_port u_port (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .rsp         (rsp),
    .rsp_valid   (rsp_valid),
    .rsp_ready   (rsp_ready),
    .bank0_cs    (bank0_cs),
    .bank0_addr  (bank0_addr),
    .bank0_wdata (bank0_wdata),
    .bank0_wren  (bank0_wren),
    .bank0_rdata (bank0_rdata),
    .bank1_cs    (bank1_cs),
    .bank1_addr  (bank1_addr),
    .bank1_wdata (bank1_wdata),
    .bank1_wren  (bank1_wren),
    .bank1_rdata (bank1_rdata)
  );

  // 16 KB at 0x0000
  sl_sram #(
    .addr_width (bank0_addr_width)
  ) u_bank0 (
    .clk   (clk),
    .addr  (bank0_addr),
    .wdata (bank0_wdata),
    .wren  (bank0_wren),
    .cs    (bank0_cs),
    .rdata (bank0_rdata)
  );

  // 32 KB at 0x8000
  sl_sram #(
    .addr_width (bank1_addr_width)
  ) u_bank1 (
    .clk   (clk),
    .addr  (bank1_addr),
    .wdata (bank1_wdata),
    .wren  (bank1_wren),
    .cs    (bank1_cs),
    .rdata (bank1_rdata)
  );

endmodule

/* test/sram_subsystem_tb.sv */
`timescale 1ns/10ps

module sram_subsystem_tb #(
  parameter int seed = 25
) ();

  import sram_map_pkg::*;
  import sram_bus_pkg::*;

  // ------------------------------------------------------------
  // Run length and time budget
  // ------------------------------------------------------------

  localparam int reset_cycles = 16;
  localparam int num_directed = 40;
  localparam int num_random   = 300;
  localparam int num_requests = num_directed + 2 * num_random;
  localparam int cycle_limit  = 2 * num_requests + reset_cycles + 200;

  logic      clk;
  logic      reset;
  sram_req_t req;
  logic      req_valid;
  logic      req_ready;
  sram_rsp_t rsp;
  logic      rsp_valid;
  logic      rsp_ready;

  // Reference memory, keyed by byte address bits 15:2
  word_t      model_mem [int];
  sram_rsp_t  exp_q [$];
  // Words fully written once, safe to read
  byte_addr_t written [$];

  logic      ready_random = 1'b0;
  logic      accepted     = 1'b0;
  logic      fired_last   = 1'b0;
  logic      stall_last   = 1'b0;
  sram_rsp_t rsp_last     = '0;
  int        cycles       = 0;

  sram_subsystem u_dut (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Checking helpers
  // ------------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error %s actual %h expected %h", name, actual, expected);
      $display("TEST FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "run aborted");
  endtask

  // Map from the address plan, hole in the middle
  function automatic bank_t region_of(input byte_addr_t addr);
    if (addr < 16'h4000) return bank_0;
    if (addr >= 16'h8000) return bank_1;
    return bank_none;
  endfunction

  // Strobed bytes take new data, rest keep the old word
  function automatic word_t merge_bytes(input word_t old, input word_t data,
                                        input strobe_t strb);
    word_t res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i +: 8] = data[8*i +: 8];
    end
    return res;
  endfunction

  // Expected response, model updated at the handshake
  task automatic record_request(input sram_req_t r);
    sram_rsp_t e;
    int        key;
    word_t     old;
    key     = int'(r.addr[15:2]);
    old     = model_mem.exists(key) ? model_mem[key] : '0;
    e.error = 1'b0;
    e.rdata = '0;
    if (region_of(r.addr) == bank_none) begin
      e.error = 1'b1;
    end else if (r.wstrb != '0) begin
      model_mem[key] = merge_bytes(old, r.wdata, r.wstrb);
    end else begin
      e.rdata = old;
    end
    exp_q.push_back(e);
  endtask

  // ------------------------------------------------------------
  // Monitor, sampled at the rising edge
  // ------------------------------------------------------------

  always @(posedge clk) begin
    sram_rsp_t e;
    accepted = 1'b0;
    if (!reset) begin
      // Valid exactly one cycle after accept, held while stalled
      check_value("rsp_valid", 32'(rsp_valid), 32'(fired_last | stall_last));
      // Ready unless a response is pending and not taken
      check_value("req_ready", 32'(req_ready), 32'(!(fired_last | stall_last) | rsp_ready));
      if (stall_last) begin
        check_value("rsp.rdata", rsp.rdata, rsp_last.rdata);
        check_value("rsp.error", 32'(rsp.error), 32'(rsp_last.error));
      end
      if (rsp_valid && rsp_ready) begin
        if (exp_q.size() == 0) begin
          abort_run("response taken with no request outstanding");
        end else begin
          e = exp_q.pop_front();
          check_value("rsp.error", 32'(rsp.error), 32'(e.error));
          check_value("rsp.rdata", rsp.rdata, e.rdata);
        end
      end
      fired_last = req_valid && req_ready;
      if (fired_last) begin
        record_request(req);
        accepted = 1'b1;
      end
      stall_last = rsp_valid && !rsp_ready;
      rsp_last   = rsp;
    end
  end

  // Run budget
  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      abort_run($sformatf("timeout after %0d cycles, responses still missing", cycles));
    end
  end

  // ------------------------------------------------------------
  // Stimulus, driven at the falling edge
  // ------------------------------------------------------------

  task automatic step();
    @(negedge clk);
    if (ready_random) rsp_ready = ($urandom % 4) != 0;
  endtask

  // Hold the request until the monitor saw it accepted
  task automatic send(input byte_addr_t addr, input word_t data, input strobe_t strb);
    req.addr  = addr;
    req.wdata = data;
    req.wstrb = strb;
    req_valid = 1'b1;
    step();
    while (!accepted) begin
      step();
    end
    req_valid = 1'b0;
  endtask

  // Hole, fresh full word write, or reuse of a known word
  task automatic send_random();
    int         kind;
    byte_addr_t addr;
    strobe_t    strb;
    kind = $urandom % 8;
    if (kind < 2) begin
      addr = 16'h4000 | byte_addr_t'($urandom % 16384);
      strb = strobe_t'($urandom);
    end else if (kind < 4 || written.size() == 0) begin
      if ($urandom % 2) addr = 16'h8000 | byte_addr_t'($urandom % 32768);
      else addr = byte_addr_t'($urandom % 16384);
      strb = 4'hf;
      written.push_back(addr);
    end else begin
      // Zero strobe here is a read
      addr = written[$urandom % written.size()];
      strb = strobe_t'($urandom);
    end
    send(addr, word_t'($urandom), strb);
  endtask

  initial begin
    void'($urandom(seed));
    req       = '0;
    req_valid = 1'b0;
    rsp_ready = 1'b0;
    reset     = 1'b1;
    repeat (reset_cycles) @(negedge clk);
    reset     = 1'b0;
    rsp_ready = 1'b1;

    // Idle after reset
    @(negedge clk);
    check_value("rsp_valid", 32'(rsp_valid), 32'h0);
    check_value("req_ready", 32'(req_ready), 32'h1);

    // Every strobe pattern on one word, each one read back
    send(16'h0100, word_t'($urandom), 4'hf);
    for (int s = 1; s < 16; s++) begin
      send(16'h0100, word_t'($urandom), strobe_t'(s));
      send(16'h0100, '0, 4'h0);
    end

    // Same offset in bank 0, bank 1 and bank 1 upper half
    send(16'h0200, 32'h1111_1111, 4'hf);
    send(16'h8200, 32'h2222_2222, 4'hf);
    send(16'hc200, 32'h3333_3333, 4'hf);
    send(16'h0200, '0, 4'h0);
    send(16'h8200, '0, 4'h0);
    send(16'hc200, '0, 4'h0);

    // Hole write must not reach bank 0
    send(16'h4200, 32'hdead_beef, 4'hf);
    send(16'h4200, '0, 4'h0);
    send(16'h0200, '0, 4'h0);

    // Streaming with rsp_ready held high
    repeat (num_random) send_random();

    // Back-pressure
    ready_random = 1'b1;
    repeat (num_random) send_random();

    // Drain
    ready_random = 1'b0;
    rsp_ready    = 1'b1;
    while (exp_q.size() != 0 || rsp_valid) begin
      step();
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

/* Makefile */
# Verilator build and run for the SRAM subsystem testbench

VERILATOR ?= verilator
TOP       ?= sram_subsystem_tb
SEED      ?= 25
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, pass when the pass line is printed"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP SEED FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Gseed=$(SEED) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
hw/sram_map_pkg.sv
hw/sram_bus_pkg.sv
hw/sram_macro.sv
hw/sl_sram.sv
hw/sram_port.sv
hw/sram_subsystem.sv
test/sram_subsystem_tb.sv
